// ==== rtl/ic_pkg.sv ====
// Shared geometry and field types for the instruction cache
// Direct mapped, 64 lines of sixteen 32-bit words, word addressed fetches only
// Address split is tag 31..12, index 11..6, word offset 5..2, bits 1..0 ignored
package ic_pkg;

  localparam int LINES        = 64; // Number of cache lines
  localparam int FETCH_DEPTH  = 4;  // Fetch queue entries, equal to the fetch unit's credits
  localparam int RESP_CREDITS = 4;  // Response credits the cache owns after reset

  // Bit positions of the address fields
  localparam int OFFSET_LSB = 2;
  localparam int INDEX_LSB  = 6;
  localparam int TAG_LSB    = 12;

  localparam int FETCH_PTR_W = $clog2(FETCH_DEPTH);
  localparam int FETCH_CNT_W = $clog2(FETCH_DEPTH + 1); // Count must also hold the full value
  localparam int CREDIT_W    = $clog2(RESP_CREDITS + 1);

  typedef logic [31:0]  addr_t;   // Fetch byte address
  typedef logic [19:0]  tag_t;    // Upper address bits stored per line
  typedef logic [5:0]   index_t;  // Line select
  typedef logic [3:0]   offset_t; // Word within a line
  typedef logic [31:0]  inst_t;   // One instruction word
  typedef logic [511:0] line_t;   // Word w sits at bits 32w+31..32w

  typedef logic [FETCH_PTR_W-1:0] fetch_ptr_t;
  typedef logic [FETCH_CNT_W-1:0] fetch_cnt_t;
  typedef logic [CREDIT_W-1:0]    credit_t;

  localparam credit_t CREDIT_INIT = credit_t'(RESP_CREDITS); // Reset value of the credit counter

  // Refill sequence, FILL is a single settle cycle after the line is written
  typedef enum logic [1:0] {
    IDLE,
    REQ,
    WAIT,
    FILL
  } refill_state_t;

endpackage

// ==== rtl/ic_fetch_buffer.sv ====
// Fetch request queue on the input side of the cache
// The sender never exceeds FETCH_DEPTH outstanding entries, so there is no full flag
// Each pop returns one credit as a registered pulse on the following cycle
`timescale 1ns/100ps

module ic_fetch_buffer (
  input  logic          clka,
  input  logic          rst_n,
  input  logic          fetch_valid,
  input  ic_pkg::addr_t fetch_addr,
  input  logic          pop,
  output logic          head_valid,
  output ic_pkg::addr_t head_addr,
  output logic          fetch_credit
);

  ic_pkg::addr_t      entries [ic_pkg::FETCH_DEPTH]; // Queued fetch addresses
  ic_pkg::fetch_ptr_t wr_ptr;
  ic_pkg::fetch_ptr_t rd_ptr;
  ic_pkg::fetch_cnt_t count;                         // Entries currently held

  // Circular increment, depth need not be a power of two
  function automatic ic_pkg::fetch_ptr_t ptr_inc(input ic_pkg::fetch_ptr_t ptr);
    return (int'(ptr) == ic_pkg::FETCH_DEPTH - 1) ? '0 : ptr + 1'b1;
  endfunction

  always_ff @(posedge clka) begin
    if (fetch_valid) entries[wr_ptr] <= fetch_addr; // Payload only, no reset
  end

  always_ff @(posedge clka) begin
    if (!rst_n) begin
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      count        <= '0;
      fetch_credit <= 1'b0;
    end else begin
      if (fetch_valid) wr_ptr <= ptr_inc(wr_ptr);
      if (pop) rd_ptr <= ptr_inc(rd_ptr);
      case ({fetch_valid, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;       // Push and pop together leave the count alone
      endcase
      fetch_credit <= pop;              // Credit goes back one cycle after the pop edge
    end
  end

  // A request written at edge N shows up as the head from cycle N+1
  assign head_valid = (count != '0);
  assign head_addr  = entries[rd_ptr];

endmodule

// ==== rtl/ic_tag_store.sv ====
// Valid bits and tags for the direct mapped cache, plus the hit test on the queue head
// The head is only popped on a hit while the output side can take another read
// A miss holds the head in place and is reported until the refill installs the tag
`timescale 1ns/100ps

module ic_tag_store (
  input  logic            clka,
  input  logic            rst_n,
  input  logic            head_valid,
  input  ic_pkg::addr_t   head_addr,
  input  logic            issue_ok,
  input  logic            fill_valid,
  input  ic_pkg::index_t  fill_index,
  input  ic_pkg::tag_t    fill_tag,
  output logic            pop,
  output ic_pkg::index_t  rd_index,
  output logic            rd_issue,
  output ic_pkg::offset_t rd_offset,
  output logic            miss,
  output ic_pkg::addr_t   miss_addr
);

  logic [ic_pkg::LINES-1:0] valid;                 // One valid bit per line
  ic_pkg::tag_t             tags [ic_pkg::LINES];  // Tag array, only meaningful where valid
  ic_pkg::index_t           head_index;
  ic_pkg::tag_t             head_tag;
  logic                     lookup_hit;

  // Field split of the head address
  assign head_index = head_addr[ic_pkg::INDEX_LSB +: $bits(ic_pkg::index_t)];
  assign head_tag   = head_addr[ic_pkg::TAG_LSB +: $bits(ic_pkg::tag_t)];

  always_ff @(posedge clka) begin
    if (!rst_n) begin
      valid <= '0;                                 // Cache starts empty
    end else if (fill_valid) begin
      valid[fill_index] <= 1'b1;
    end
  end

  always_ff @(posedge clka) begin
    if (fill_valid) tags[fill_index] <= fill_tag; // Tag lands in the same cycle as the line
  end

  // Hit test is purely combinational on the current head
  assign lookup_hit = head_valid && valid[head_index] && (tags[head_index] == head_tag);

  // A hit leaves the queue and starts the array read at the same edge
  assign pop       = lookup_hit && issue_ok;
  assign rd_issue  = pop;
  assign rd_index  = head_index;                   // Sampled by the array at the pop edge
  assign rd_offset = head_addr[ic_pkg::OFFSET_LSB +: $bits(ic_pkg::offset_t)];

  // Miss drops in the fill cycle, the head then hits on the next cycle
  assign miss      = head_valid && !lookup_hit && !fill_valid;
  assign miss_addr = head_addr;

endmodule

// ==== rtl/ic_refill_ctrl.sv ====
// Refill sequencer for one missing line at a time
// The memory side has no flow control, one request is outstanding until its response
// The response cycle writes the line and tag directly, mem_resp_line feeds the array
`timescale 1ns/100ps

module ic_refill_ctrl (
  input  logic           clka,
  input  logic           rst_n,
  input  logic           miss,
  input  ic_pkg::addr_t  miss_addr,
  input  logic           mem_resp_valid,
  output logic           mem_req_valid,
  output ic_pkg::addr_t  mem_req_addr,
  output logic           fill_valid,
  output ic_pkg::index_t fill_index,
  output ic_pkg::tag_t   fill_tag
);

  ic_pkg::refill_state_t state;
  ic_pkg::refill_state_t state_next;
  ic_pkg::addr_t         line_addr;               // Line aligned address of the refill

  always_ff @(posedge clka) begin
    if (!rst_n) state <= ic_pkg::IDLE;
    else        state <= state_next;
  end

  // Capture the miss when idle, word offset bits cleared
  always_ff @(posedge clka) begin
    if (state == ic_pkg::IDLE && miss) begin
      line_addr <= {miss_addr[$bits(ic_pkg::addr_t)-1:ic_pkg::INDEX_LSB],
                    {ic_pkg::INDEX_LSB{1'b0}}};
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      ic_pkg::IDLE: if (miss) state_next = ic_pkg::REQ;
      ic_pkg::REQ:  state_next = ic_pkg::WAIT;           // Request is a single cycle
      ic_pkg::WAIT: if (mem_resp_valid) state_next = ic_pkg::FILL;
      ic_pkg::FILL: state_next = ic_pkg::IDLE;           // Let the new tag settle
      default:      state_next = ic_pkg::IDLE;
    endcase
  end

  assign mem_req_valid = (state == ic_pkg::REQ);
  assign mem_req_addr  = line_addr;

  // The write happens in the cycle memory answers, its data is only valid then
  assign fill_valid = (state == ic_pkg::WAIT) && mem_resp_valid;
  assign fill_index = line_addr[ic_pkg::INDEX_LSB +: $bits(ic_pkg::index_t)];
  assign fill_tag   = line_addr[ic_pkg::TAG_LSB +: $bits(ic_pkg::tag_t)];

endmodule

// ==== rtl/inst_cache_memory.sv ====
// Simple dual-port line store, write on port a and registered read on port b
// One clock for both ports, read data is valid one cycle after the address edge
// A write and read of the same entry in one cycle returns the newly written data
// Contents start at zero through the initial block, there is no reset port
`timescale 1ns/100ps

module inst_cache_memory #(
  parameter int RAM_WIDTH = 512, // Bits per entry
  parameter int RAM_DEPTH = 64   // Entries, sets the address width
) (
  input  logic                         clka,
  input  logic [$clog2(RAM_DEPTH)-1:0] addra, // Write address
  input  logic [$clog2(RAM_DEPTH)-1:0] addrb, // Read address
  input  logic [RAM_WIDTH-1:0]         dina,
  input  logic                         wea,
  output logic [RAM_WIDTH-1:0]         doutb
);

  logic [RAM_WIDTH-1:0] mem [RAM_DEPTH];
  logic [RAM_WIDTH-1:0] wr_data_q;  // Last written data, used for forwarding
  logic [RAM_WIDTH-1:0] rd_data_q;  // Registered array read
  logic                 bypass_q;   // Previous cycle wrote the entry being read

  initial begin
    for (int i = 0; i < RAM_DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  always_ff @(posedge clka) begin
    if (wea) mem[addra] <= dina;
  end

  // The array read sees the old entry on a collision, so the bypass supplies the new one
  always_ff @(posedge clka) begin
    rd_data_q <= mem[addrb];
    wr_data_q <= dina;
    bypass_q  <= wea && (addra == addrb); // Only a real write may override the read
  end

  assign doutb = bypass_q ? wr_data_q : rd_data_q;

endmodule

// ==== rtl/ic_resp_out.sv ====
// Output side of the cache, word select and response credit accounting
// The consumer grants RESP_CREDITS after reset and returns one per response taken
// issue_ok keeps reads already in flight covered by credits, so responses never stall
`timescale 1ns/100ps

module ic_resp_out (
  input  logic            clka,
  input  logic            rst_n,
  input  logic            rd_issue,
  input  ic_pkg::offset_t rd_offset,
  input  ic_pkg::line_t   rd_line,
  input  logic            resp_credit,
  output logic            issue_ok,
  output logic            resp_valid,
  output ic_pkg::inst_t   resp_inst
);

  logic            rd_issue_q;  // Read issued last cycle, its line is on rd_line now
  ic_pkg::offset_t rd_offset_q; // Word offset travelling with that read
  ic_pkg::credit_t credits;     // Responses the consumer can still take
  ic_pkg::credit_t in_flight;   // Reads issued but not yet answered

  always_ff @(posedge clka) begin
    rd_offset_q <= rd_offset;   // Payload, qualified by rd_issue_q
  end

  always_ff @(posedge clka) begin
    if (!rst_n) begin
      rd_issue_q <= 1'b0;
      credits    <= ic_pkg::CREDIT_INIT;
      in_flight  <= '0;
    end else begin
      rd_issue_q <= rd_issue;
      case ({resp_credit, resp_valid})
        2'b10:   credits <= credits + 1'b1;
        2'b01:   credits <= credits - 1'b1;
        default: credits <= credits;     // Return and spend cancel out
      endcase
      case ({rd_issue, resp_valid})
        2'b10:   in_flight <= in_flight + 1'b1;
        2'b01:   in_flight <= in_flight - 1'b1;
        default: in_flight <= in_flight;
      endcase
    end
  end

  // Another read may start only if a credit is left after all reads in flight
  assign issue_ok = (credits > in_flight);

  assign resp_valid = rd_issue_q;
  assign resp_inst  = rd_line[{rd_offset_q, 5'd0} +: $bits(ic_pkg::inst_t)]; // Word w at 32w

endmodule

// ==== rtl/icache_top.sv ====
// Instruction cache top, direct mapped with a single outstanding refill
// Fetch side and response side both run on credits, responses leave in request order
// Memory side is a plain request and one-cycle response carrying a whole line
`timescale 1ns/100ps

module icache_top (
  input  logic          clka,
  input  logic          rst_n,
  input  logic          fetch_valid,
  input  ic_pkg::addr_t fetch_addr,
  input  logic          mem_resp_valid,
  input  ic_pkg::line_t mem_resp_line,
  input  logic          resp_credit,
  output logic          fetch_credit,
  output logic          mem_req_valid,
  output ic_pkg::addr_t mem_req_addr,
  output logic          resp_valid,
  output ic_pkg::inst_t resp_inst
);

  logic            head_valid;
  ic_pkg::addr_t   head_addr;
  logic            pop;
  logic            issue_ok;
  ic_pkg::index_t  rd_index;
  logic            rd_issue;
  ic_pkg::offset_t rd_offset;
  logic            miss;
  ic_pkg::addr_t   miss_addr;
  logic            fill_valid;
  ic_pkg::index_t  fill_index;
  ic_pkg::tag_t    fill_tag;
  ic_pkg::line_t   rd_line;

  ic_fetch_buffer u_fetch_buffer (
    .clka(clka), .rst_n(rst_n), .fetch_valid(fetch_valid), .fetch_addr(fetch_addr),
    .pop(pop), .head_valid(head_valid), .head_addr(head_addr), .fetch_credit(fetch_credit)
  );

  ic_tag_store u_tag_store (
    .clka(clka), .rst_n(rst_n), .head_valid(head_valid), .head_addr(head_addr),
    .issue_ok(issue_ok), .fill_valid(fill_valid), .fill_index(fill_index),
    .fill_tag(fill_tag), .pop(pop), .rd_index(rd_index), .rd_issue(rd_issue),
    .rd_offset(rd_offset), .miss(miss), .miss_addr(miss_addr)
  );

  ic_refill_ctrl u_refill_ctrl (
    .clka(clka), .rst_n(rst_n), .miss(miss), .miss_addr(miss_addr),
    .mem_resp_valid(mem_resp_valid), .mem_req_valid(mem_req_valid),
    .mem_req_addr(mem_req_addr), .fill_valid(fill_valid), .fill_index(fill_index),
    .fill_tag(fill_tag)
  );

  // Refill data goes straight from memory into the write port
  inst_cache_memory #(
    .RAM_WIDTH($bits(ic_pkg::line_t)),
    .RAM_DEPTH(ic_pkg::LINES)
  ) u_inst_cache_memory (
    .clka(clka), .addra(fill_index), .addrb(rd_index), .dina(mem_resp_line),
    .wea(fill_valid), .doutb(rd_line)
  );

  ic_resp_out u_resp_out (
    .clka(clka), .rst_n(rst_n), .rd_issue(rd_issue), .rd_offset(rd_offset),
    .rd_line(rd_line), .resp_credit(resp_credit), .issue_ok(issue_ok),
    .resp_valid(resp_valid), .resp_inst(resp_inst)
  );

endmodule

// ==== verif/icache_checker.sv ====
// Watches the cache ports and predicts every response from the memory line rule
// Misses come from a shadow tag copy that is updated at fetch time
// The copy tracks the cache because refills are served in request order
`timescale 1ns/100ps

module icache_checker (
  input  logic          clka,
  input  logic          rst_n,
  input  logic          fetch_valid,
  input  ic_pkg::addr_t fetch_addr,
  input  logic          fetch_credit,
  input  logic          mem_req_valid,
  input  ic_pkg::addr_t mem_req_addr,
  input  logic          resp_valid,
  input  ic_pkg::inst_t resp_inst,
  input  logic          resp_credit,
  input  logic          test_end,
  input  int            test_id,
  output int            error_count,
  output int            resp_count,
  output int            mem_req_count
);

  ic_pkg::inst_t exp_inst [$];      // Instructions still owed with the oldest first
  ic_pkg::addr_t exp_line [$];      // Line requests still owed
  logic [63:0]   shadow_valid;
  ic_pkg::tag_t  shadow_tag [64];
  int            outstanding;       // Responses the consumer has not paid back
  int            fetch_count;       // Fetches taken by the cache
  int            credit_count;      // Fetch credits handed back to the sender
  int            last_resp;
  int            last_req;
  int            last_err;

  always @(posedge clka) begin : watch
    logic [5:0]    idx;
    ic_pkg::tag_t  tag;
    ic_pkg::inst_t expected;
    ic_pkg::addr_t line_addr;
    if (!rst_n) begin
      exp_inst.delete();
      exp_line.delete();
      shadow_valid  = '0;            // Cache starts empty
      outstanding   = 0;
      fetch_count   = 0;
      credit_count  = 0;
      error_count   = 0;
      resp_count    = 0;
      mem_req_count = 0;
      last_resp     = 0;
      last_req      = 0;
      last_err      = 0;
    end else begin
      if (fetch_valid) begin
        idx = fetch_addr[11:6];
        tag = fetch_addr[31:12];
        fetch_count++;
        exp_inst.push_back({fetch_addr[31:2], 2'b00} ^ 32'hA5A5_0000); // Word address XOR pattern
        if (!shadow_valid[idx] || shadow_tag[idx] != tag) begin
          exp_line.push_back({fetch_addr[31:6], 6'd0});
          shadow_valid[idx] = 1'b1;
          shadow_tag[idx]   = tag;
        end
      end
      if (fetch_credit) credit_count++; // One credit per entry that left the fetch queue
      if (mem_req_valid) begin
        mem_req_count++;
        if (exp_line.size() == 0) begin
          $display("ERROR at %0t: line request for %h with no miss expected", $time, mem_req_addr);
          error_count++;
        end else begin
          line_addr = exp_line.pop_front();
          if (mem_req_addr !== line_addr) begin
            $display("FAILED at %0t: mem_req_addr expected %h actual %h", $time, line_addr,
                     mem_req_addr);
            error_count++;
          end
        end
      end
      if (resp_valid) begin
        resp_count++;
        outstanding++;
        if (exp_inst.size() == 0) begin
          $display("ERROR at %0t: response arrived with no request waiting", $time);
          error_count++;
        end else begin
          expected = exp_inst.pop_front();
          if (resp_inst !== expected) begin
            $display("FAILED at %0t: resp_inst expected %h actual %h", $time, expected, resp_inst);
            error_count++;
          end
        end
      end
      if (resp_credit) outstanding--;
      if (outstanding > ic_pkg::RESP_CREDITS) begin
        $display("ERROR at %0t: more responses outstanding than response credits", $time);
        error_count++;
      end
      if (test_end) begin
        if (exp_line.size() != 0) begin
          $display("ERROR at %0t: %0d predicted misses never requested a line", $time,
                   exp_line.size());
          error_count++;
        end
        // With the queue drained every fetch has had its credit returned
        if (credit_count != fetch_count) begin
          $display("FAILED at %0t: fetch_credit count expected %0d actual %0d", $time,
                   fetch_count, credit_count);
          error_count++;
        end
        $display("Test %0d finished: %0d responses, %0d memory requests, %0d errors", test_id,
                 resp_count - last_resp, mem_req_count - last_req, error_count - last_err);
        last_resp = resp_count;
        last_req  = mem_req_count;
        last_err  = error_count;
      end
    end
  end

endmodule

// ==== verif/icache_tb.sv ====
// Testbench for the instruction cache that runs a fixed table of fetches in request order
// Memory answers each line request after 2 to 9 cycles
// Word w of the line at base b holds (b+4w) ^ A5A50000
// A row with hold set must start a new test, and its group needs more rows than RESP_CREDITS
`timescale 1ns/100ps

module icache_tb;

  localparam int NUM_ROWS = 25;
  localparam int TIMEOUT  = 2000; // Cycles allowed for any single wait

  typedef struct packed {
    logic [3:0]    test; // A new test number closes the previous test
    ic_pkg::addr_t addr;
    logic [3:0]    idle; // Idle cycles before the request
    logic          hold; // Consumer keeps its response credits
    logic          miss; // Row is expected to request a line
  } row_t;

  logic          clka = 1'b0;
  logic          rst_n;
  logic          fetch_valid;
  ic_pkg::addr_t fetch_addr;
  logic          mem_resp_valid = 1'b0;
  ic_pkg::line_t mem_resp_line  = '0;
  logic          resp_credit    = 1'b0;
  logic          fetch_credit;
  logic          mem_req_valid;
  ic_pkg::addr_t mem_req_addr;
  logic          resp_valid;
  ic_pkg::inst_t resp_inst;
  logic          test_end;
  int            test_id;
  int            chk_errors;
  int            resp_count;
  int            mem_req_count;
  row_t          rows [NUM_ROWS];
  integer        seed             = 8925;
  int            sent             = 0; // Fetches issued so far
  int            credits_returned = 0;
  int            owed_credits     = 0; // Responses whose credit the cache has not seen yet
  int            tb_errors        = 0;
  int            exp_miss         = 0;
  int            req_base         = 0;
  bit            hold_credits     = 1'b0;
  bit            aborted          = 1'b0;

  always #5 clka = ~clka;

  icache_top u_icache_top (
    .clka(clka), .rst_n(rst_n), .fetch_valid(fetch_valid), .fetch_addr(fetch_addr),
    .mem_resp_valid(mem_resp_valid), .mem_resp_line(mem_resp_line), .resp_credit(resp_credit),
    .fetch_credit(fetch_credit), .mem_req_valid(mem_req_valid), .mem_req_addr(mem_req_addr),
    .resp_valid(resp_valid), .resp_inst(resp_inst)
  );

  icache_checker u_checker (
    .clka(clka), .rst_n(rst_n), .fetch_valid(fetch_valid), .fetch_addr(fetch_addr),
    .fetch_credit(fetch_credit), .mem_req_valid(mem_req_valid), .mem_req_addr(mem_req_addr),
    .resp_valid(resp_valid), .resp_inst(resp_inst), .resp_credit(resp_credit),
    .test_end(test_end), .test_id(test_id), .error_count(chk_errors), .resp_count(resp_count),
    .mem_req_count(mem_req_count)
  );

  always @(posedge clka) begin
    if (fetch_credit) credits_returned++; // Fetch unit regains one credit per pulse
  end

  // Next-level memory model that serves one line request at a time
  always begin : memory_model
    ic_pkg::addr_t base;
    int            latency;
    @(posedge clka);
    if (rst_n && mem_req_valid) begin
      base    = mem_req_addr;
      latency = 2 + ({$random(seed)} % 8);
      repeat (latency - 1) @(posedge clka);
      #1;
      mem_resp_valid = 1'b1;
      for (int w = 0; w < 16; w++) begin
        mem_resp_line[32*w +: 32] = (base + 32'(4 * w)) ^ 32'hA5A5_0000;
      end
      @(posedge clka);
      #1;
      mem_resp_valid = 1'b0;
    end
  end

  // Consumer pays back each response after a random delay unless credits are held
  always begin : consumer
    bit may_return;
    @(posedge clka);
    if (rst_n && resp_valid) owed_credits++;
    if (resp_credit) owed_credits--;                // The cache takes the credit at this edge
    may_return = !hold_credits && owed_credits > 0; // Decided on the edge, driven just after
    #1;
    resp_credit = 1'b0;
    if (may_return && ({$random(seed)} % 3) != 0) resp_credit = 1'b1;
  end

  task step();
    @(posedge clka);
    #1; // Inputs change a little after the edge
  endtask

  function automatic bit cond_met(input int kind);
    case (kind)
      0:       return (ic_pkg::FETCH_DEPTH + credits_returned - sent) > 0;
      1:       return resp_count == sent;
      2:       return owed_credits == ic_pkg::RESP_CREDITS;
      default: return owed_credits == 0;
    endcase
  endfunction

  task automatic wait_for(input int kind, input string what);
    int n;
    n = 0;
    while (!cond_met(kind) && n < TIMEOUT) begin
      step();
      n++;
    end
    if (!cond_met(kind)) begin
      $display("ERROR at %0t: timed out waiting for %s", $time, what);
      aborted = 1'b1;
    end
  endtask

  task automatic send_row(input int r);
    repeat (rows[r].idle) step();
    wait_for(0, "a fetch credit");
    if (aborted) return;
    fetch_valid = 1'b1;
    fetch_addr  = rows[r].addr;
    sent++;
    exp_miss += int'(rows[r].miss);
    step();
    fetch_valid = 1'b0;
  endtask

  // Drain one test, check the stall while credits are held, then report it
  task automatic close_test(input int id);
    int credits_before;
    int resp_before;
    if (hold_credits) begin
      wait_for(2, "the consumer to hold every response credit");
      if (aborted) return;
      credits_before = credits_returned;
      resp_before    = resp_count;
      repeat (10) step();
      if (credits_returned != credits_before || resp_count != resp_before) begin
        $display("ERROR at %0t: cache kept answering with no response credits", $time);
        tb_errors++;
      end
      hold_credits = 1'b0; // Releasing the credits lets the queued fetches complete
    end
    wait_for(1, "all responses");
    if (aborted) return;
    wait_for(3, "the consumer to return its credits");
    if (aborted) return;
    if (mem_req_count - req_base != exp_miss) begin
      $display("FAILED at %0t: mem_req_valid count expected %0d actual %0d", $time, exp_miss,
               mem_req_count - req_base);
      tb_errors++;
    end
    test_id  = id;
    test_end = 1'b1;
    step();
    test_end = 1'b0;
  endtask

  initial begin : main
    int cur_test;
    rst_n       = 1'b0;
    fetch_valid = 1'b0;
    fetch_addr  = '0;
    test_end    = 1'b0;
    test_id     = 0;
    // Test 1 cold miss, 2 hits in that line, 3 conflict on index 2, 4 mixed order,
    // 5 credits held, 6 refill followed at once by a hit
    rows = '{
      '{4'd1, 32'h0000_1040, 4'd2, 1'b0, 1'b1},
      '{4'd2, 32'h0000_1044, 4'd1, 1'b0, 1'b0}, '{4'd2, 32'h0000_1048, 4'd0, 1'b0, 1'b0},
      '{4'd2, 32'h0000_107C, 4'd0, 1'b0, 1'b0},
      '{4'd3, 32'h0000_2080, 4'd1, 1'b0, 1'b1}, '{4'd3, 32'h0000_3080, 4'd0, 1'b0, 1'b1},
      '{4'd3, 32'h0000_2084, 4'd0, 1'b0, 1'b1}, '{4'd3, 32'h0000_3088, 4'd2, 1'b0, 1'b1},
      '{4'd3, 32'h0000_308C, 4'd0, 1'b0, 1'b0},
      '{4'd4, 32'h0000_1040, 4'd0, 1'b0, 1'b0}, '{4'd4, 32'h0000_104C, 4'd0, 1'b0, 1'b0},
      '{4'd4, 32'h0000_5100, 4'd0, 1'b0, 1'b1}, '{4'd4, 32'h0000_1058, 4'd0, 1'b0, 1'b0},
      '{4'd4, 32'h0000_6140, 4'd0, 1'b0, 1'b1}, '{4'd4, 32'h0000_5104, 4'd0, 1'b0, 1'b0},
      '{4'd5, 32'h0000_1040, 4'd0, 1'b1, 1'b0}, '{4'd5, 32'h0000_1044, 4'd0, 1'b1, 1'b0},
      '{4'd5, 32'h0000_5100, 4'd0, 1'b1, 1'b0}, '{4'd5, 32'h0000_7180, 4'd0, 1'b1, 1'b1},
      '{4'd5, 32'h0000_1048, 4'd0, 1'b1, 1'b0}, '{4'd5, 32'h0000_7184, 4'd0, 1'b1, 1'b0},
      '{4'd6, 32'h0000_8200, 4'd0, 1'b0, 1'b1}, '{4'd6, 32'h0000_823C, 4'd0, 1'b0, 1'b0},
      '{4'd6, 32'h0000_9240, 4'd1, 1'b0, 1'b1}, '{4'd6, 32'h0000_9244, 4'd0, 1'b0, 1'b0}
    };
    repeat (3) @(posedge clka);
    #1;
    rst_n    = 1'b1;
    cur_test = int'(rows[0].test);
    for (int r = 0; r < NUM_ROWS && !aborted; r++) begin
      if (int'(rows[r].test) != cur_test) begin
        close_test(cur_test);
        cur_test = int'(rows[r].test);
        exp_miss = 0;
        req_base = mem_req_count;
      end
      if (!aborted) begin
        hold_credits = hold_credits | rows[r].hold;
        send_row(r);
      end
    end
    if (!aborted) close_test(cur_test);
    $display("Totals: %0d requests, %0d responses, %0d memory requests, %0d errors", sent,
             resp_count, mem_req_count, chk_errors + tb_errors);
    if (!aborted && chk_errors + tb_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== list.f ====
rtl/ic_pkg.sv
rtl/ic_fetch_buffer.sv
rtl/ic_tag_store.sv
rtl/ic_refill_ctrl.sv
rtl/inst_cache_memory.sv
rtl/ic_resp_out.sv
rtl/icache_top.sv
verif/icache_checker.sv
verif/icache_tb.sv

// ==== Makefile ====
# Verilator build and run for the instruction cache testbench
VERILATOR ?= verilator
TOP       ?= icache_tb
FLIST     ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SRCS := $(shell cat $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
